/* tb/ex_golden.txt */
# kind op a b c flags exp_word exp_flag, all hex
# flags bit0 we, bit1 lsu_err, bit2 csr_access, bit3 branch_in_ex, bit4 wb_ready low
alu   0 7fffffff 00000001 00000000 01 80000000 0
alu   1 00000003 00000005 00000000 01 fffffffe 0
alu   2 ff00ff00 0ff00ff0 00000000 01 f0f0f0f0 0
alu   3 12340000 00005678 00000000 00 12345678 0
alu   4 f0f0f0f0 3c3c3c3c 00000000 01 30303030 0
alu   5 12345678 00000024 00000000 01 23456780 0
alu   6 80000000 00000004 00000000 01 08000000 0
alu   7 80000000 00000004 00000000 01 f8000000 0
alu   8 ffffffff 00000001 00000000 01 00000001 0
alu   9 ffffffff 00000001 00000000 01 00000000 0
alu   a 0000abcd 0000abcd 00001000 18 00000001 1
alu   b 0000abcd 0000abce 00002000 18 00000001 1
alu   c 80000000 00000001 00003000 18 00000001 1
alu   d 80000000 00000001 00004000 18 00000000 0
alu   e 80000000 00000001 00005000 18 00000000 0
alu   f 80000000 00000001 00006000 18 00000001 1
alu   0 00000001 00000002 cafe0001 05 cafe0001 0
mul   0 00000007 00000006 00000000 01 0000002a 0
mul   0 ffffffff ffffffff 00000000 01 00000001 0
mul   1 ffffffff ffffffff 00000000 01 00000000 0
mul   1 80000000 80000000 00000000 01 40000000 0
mul   2 ffffffff 00000002 00000000 01 ffffffff 0
mul   3 ffffffff ffffffff 00000000 01 fffffffe 0
lsu   0 deadbeef 0000000a 00000000 01 0000000a 1
lsu   0 12345678 0000000b 00000000 03 00000000 0
lsu   0 a5a5a5a5 00000021 00000000 01 00000021 1
stall 0 11112222 00000003 00000004 01 00000004 1
stall 0 33334444 00000011 00000022 01 00000022 1

/* tb.f */
+incdir+verilog
verilog/ex_op_pkg.sv
verilog/ex_pipe_pkg.sv
verilog/ex_alu.sv
verilog/ex_mult.sv
verilog/ex_ctrl.sv
verilog/ex_stage.sv
tb/ex_stage_assert.sv
tb/tb_ex_stage.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  # Execute stage RTL
  - include_dirs:
      - verilog
    files:
      - verilog/ex_op_pkg.sv
      - verilog/ex_pipe_pkg.sv
      - verilog/ex_alu.sv
      - verilog/ex_mult.sv
      - verilog/ex_ctrl.sv
      - verilog/ex_stage.sv

  # Testbench and bound checkers
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/ex_stage_assert.sv
      - tb/tb_ex_stage.sv

/* tb/tb_ex_stage.sv */
////////////////////
// Execute stage testbench
// Golden vectors through ALU, multiplier, LSU port and WB stalls
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module tb_ex_stage import ex_op_pkg::*, ex_pipe_pkg::*; ();

  localparam int    CLK_PERIOD = 20;
  localparam int    QTR        = CLK_PERIOD / 4;  // Sample point after the falling edge
  localparam int    RST_CYCLES = 4;
  localparam string GOLDEN     = "tb/ex_golden.txt";

  logic      clk;
  logic      rst_n;
  alu_op_e   alu_operator;
  mul_op_e   mult_operator;
  logic      alu_en, mult_en, csr_access, lsu_en, lsu_ready_ex, lsu_err, branch_in_ex;
  logic      regfile_alu_we, regfile_we, wb_ready;
  word_t     op_a, op_b, op_c, csr_rdata, lsu_rdata;
  reg_addr_t regfile_alu_waddr, regfile_waddr;
  logic      mult_multicycle, branch_decision, alu_we_fw, we_wb, ex_ready, ex_valid;
  word_t     jump_target, alu_wdata_fw, wdata_wb;
  reg_addr_t alu_waddr_fw, waddr_wb;

  // Golden columns
  logic [63:0] v_kind [$];
  logic [31:0] v_op [$], v_a [$], v_b [$], v_c [$], v_flags [$], v_word [$], v_flag [$];

  int          errors = 0;
  logic        loaded = 1'b0;     // Releases the watchdog
  string       cur_test = "init";
  logic [31:0] lfsr_state = 32'd76409;

  ex_stage dut (
    .clk (clk), .rst_n (rst_n),
    .alu_operator_i (alu_operator), .alu_en_i (alu_en),
    .alu_operand_a_i (op_a), .alu_operand_b_i (op_b), .alu_operand_c_i (op_c),
    .mult_operator_i (mult_operator), .mult_en_i (mult_en),
    .mult_operand_a_i (op_a), .mult_operand_b_i (op_b),  // Shared operand buses
    .csr_access_i (csr_access), .csr_rdata_i (csr_rdata),
    .lsu_en_i (lsu_en), .lsu_rdata_i (lsu_rdata),
    .lsu_ready_ex_i (lsu_ready_ex), .lsu_err_i (lsu_err), .branch_in_ex_i (branch_in_ex),
    .regfile_alu_we_i (regfile_alu_we), .regfile_alu_waddr_i (regfile_alu_waddr),
    .regfile_we_i (regfile_we), .regfile_waddr_i (regfile_waddr), .wb_ready_i (wb_ready),
    .mult_multicycle_o (mult_multicycle), .branch_decision_o (branch_decision),
    .jump_target_o (jump_target),
    .regfile_alu_we_fw_o (alu_we_fw), .regfile_alu_waddr_fw_o (alu_waddr_fw),
    .regfile_alu_wdata_fw_o (alu_wdata_fw),
    .regfile_we_wb_o (we_wb), .regfile_waddr_wb_o (waddr_wb), .regfile_wdata_wb_o (wdata_wb),
    .ex_ready_o (ex_ready), .ex_valid_o (ex_valid)
  );

  bind ex_stage ex_stage_assert u_assert (
    .clk               (clk),
    .rst_n             (rst_n),
    .mult_multicycle_i (mult_multicycle_o),
    .ex_ready_i        (ex_ready_o),
    .branch_in_ex_i    (branch_in_ex_i),
    .ex_valid_i        (ex_valid_o),
    .wb_ready_i        (wb_ready_i),
    .regfile_we_wb_i   (regfile_we_wb_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic random_bits(input int n, output int val);
    val = 0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);  // One step per bit
      val = (val << 1) | lfsr_state[0];
    end
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] exp, act);
    errors++;
    $display("[FAIL] %s %s expected %h actual %h", cur_test, what, exp, act);
  endtask

  task automatic load_golden();
    int          fd;
    int          n;
    string       line;
    logic [63:0] kind;
    logic [31:0] op, a, b, c, flags, word, flag;
    fd = $fopen(GOLDEN, "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open golden vector file %s", GOLDEN);
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      n = $sscanf(line, "%s %h %h %h %h %h %h %h", kind, op, a, b, c, flags, word, flag);
      if (n == 8) begin                     // Comment and blank lines fall out here
        v_kind.push_back(kind);
        v_op.push_back(op);
        v_a.push_back(a);
        v_b.push_back(b);
        v_c.push_back(c);
        v_flags.push_back(flags);
        v_word.push_back(word);
        v_flag.push_back(flag);
      end
    end
    $fclose(fd);
  endtask

  // Nothing in flight with WB and LSU ready
  task automatic drive_idle();
    alu_en         = 1'b0;
    mult_en        = 1'b0;
    csr_access     = 1'b0;
    lsu_en         = 1'b0;
    lsu_err        = 1'b0;
    branch_in_ex   = 1'b0;
    regfile_alu_we = 1'b0;
    regfile_we     = 1'b0;
    lsu_ready_ex   = 1'b1;
    wb_ready       = 1'b1;
  endtask

  // Load/store port one cycle after the accepted cycle
  task automatic check_wb(input int i);
    if (we_wb !== v_flag[i][0])
      report_mismatch("wb we", v_flag[i][0], we_wb);
    if (v_flag[i][0] && (waddr_wb !== v_word[i][`EX_REG_ADDR_W-1:0]))
      report_mismatch("wb addr", v_word[i], waddr_wb);
    if (wdata_wb !== v_a[i])
      report_mismatch("wb data", v_a[i], wdata_wb);
  endtask

  ////////////////////
  // Vector kinds
  ////////////////////
  task automatic run_alu(input int i);
    reg_addr_t fw_addr;
    @(negedge clk);
    drive_idle();
    cur_test          = $sformatf("vector %0d alu", i);
    fw_addr           = reg_addr_t'(i + 1);  // New target per vector
    alu_en            = 1'b1;
    alu_operator      = alu_op_e'(v_op[i][3:0]);
    op_a              = v_a[i];
    op_b              = v_b[i];
    op_c              = v_c[i];
    csr_rdata         = v_c[i];           // CSR data rides on column C
    regfile_alu_we    = v_flags[i][0];
    regfile_alu_waddr = fw_addr;
    csr_access        = v_flags[i][2];
    branch_in_ex      = v_flags[i][3];
    wb_ready          = ~v_flags[i][4];
    #(QTR);
    if (alu_wdata_fw !== v_word[i])
      report_mismatch("fw data", v_word[i], alu_wdata_fw);
    if (alu_we_fw !== v_flags[i][0])
      report_mismatch("fw we", v_flags[i][0], alu_we_fw);
    if (alu_waddr_fw !== fw_addr)
      report_mismatch("fw addr", fw_addr, alu_waddr_fw);
    if (v_flags[i][3]) begin
      if (branch_decision !== v_flag[i][0])
        report_mismatch("branch decision", v_flag[i][0], branch_decision);
      if (jump_target !== v_c[i])
        report_mismatch("jump target", v_c[i], jump_target);
      if (ex_ready !== 1'b1)
        report_mismatch("ex_ready on branch", 1, ex_ready);
    end
    @(posedge clk);
  endtask

  task automatic run_mul(input int i);
    int stalls;
    int exp_stalls;
    @(negedge clk);
    drive_idle();
    cur_test       = $sformatf("vector %0d mul", i);
    mult_en        = 1'b1;
    mult_operator  = mul_op_e'(v_op[i][1:0]);
    op_a           = v_a[i];
    op_b           = v_b[i];
    regfile_alu_we = v_flags[i][0];
    exp_stalls     = (mult_operator == MUL_MUL) ? 0 : `EX_MULH_CYCLES - 1;
    stalls         = 0;
    #(QTR);
    while ((ex_ready !== 1'b1) && (stalls <= `EX_MULH_CYCLES)) begin
      if (mult_multicycle !== 1'b1)
        report_mismatch("multicycle while busy", 1, mult_multicycle);
      stalls++;
      @(negedge clk);
      #(QTR);
    end
    if (stalls != exp_stalls)
      report_mismatch("busy cycles", exp_stalls, stalls);
    if (mult_multicycle !== 1'b0)
      report_mismatch("multicycle when done", 0, mult_multicycle);
    if (alu_wdata_fw !== v_word[i])
      report_mismatch("fw data", v_word[i], alu_wdata_fw);
    @(posedge clk);
  endtask

  task automatic run_lsu(input int i);
    @(negedge clk);
    drive_idle();
    cur_test      = $sformatf("vector %0d lsu", i);
    lsu_en        = 1'b1;
    regfile_we    = v_flags[i][0];
    lsu_err       = v_flags[i][1];
    regfile_waddr = v_b[i][`EX_REG_ADDR_W-1:0];
    lsu_rdata     = v_a[i];
    #(QTR);
    if (ex_valid !== 1'b1)
      report_mismatch("ex_valid", 1, ex_valid);
    @(negedge clk);
    check_wb(i);
  endtask

  // Write B, stall WB for a random length, then write C
  task automatic run_stall(input int i);
    int len;
    @(negedge clk);
    drive_idle();
    cur_test      = $sformatf("vector %0d stall", i);
    lsu_en        = 1'b1;
    regfile_we    = 1'b1;
    regfile_waddr = v_b[i][`EX_REG_ADDR_W-1:0];
    lsu_rdata     = v_a[i];
    @(negedge clk);
    regfile_waddr = v_c[i][`EX_REG_ADDR_W-1:0];
    wb_ready      = 1'b0;
    random_bits(3, len);
    len = len + 1;                     // 1 to 8 stall cycles
    repeat (len) begin
      #(QTR);
      if (ex_ready !== 1'b0)
        report_mismatch("ex_ready in stall", 0, ex_ready);
      if (ex_valid !== 1'b0)
        report_mismatch("ex_valid in stall", 0, ex_valid);
      @(negedge clk);
      if (we_wb !== 1'b1)
        report_mismatch("wb we held", 1, we_wb);
      if (waddr_wb !== v_b[i][`EX_REG_ADDR_W-1:0])
        report_mismatch("wb addr held", v_b[i], waddr_wb);
    end
    wb_ready = 1'b1;
    #(QTR);
    if (ex_valid !== 1'b1)
      report_mismatch("ex_valid after stall", 1, ex_valid);
    @(negedge clk);
    check_wb(i);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    int n_vec;
    drive_idle();
    alu_operator      = ALU_ADD;
    mult_operator     = MUL_MUL;
    op_a              = '0;
    op_b              = '0;
    op_c              = '0;
    csr_rdata         = '0;
    lsu_rdata         = '0;
    regfile_alu_waddr = '0;
    regfile_waddr     = '0;
    rst_n             = 1'b0;
    load_golden();
    n_vec  = v_kind.size();
    loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #(QTR);
    cur_test = "reset";
    if (we_wb !== 1'b0)
      report_mismatch("wb we", 0, we_wb);
    if (mult_multicycle !== 1'b0)
      report_mismatch("multicycle", 0, mult_multicycle);
    for (int i = 0; i < n_vec; i++) begin
      if (v_kind[i] == "alu") run_alu(i);
      else if (v_kind[i] == "mul") run_mul(i);
      else if (v_kind[i] == "lsu") run_lsu(i);
      else if (v_kind[i] == "stall") run_stall(i);
      else begin
        errors++;
        $display("Golden entry %0d has an unknown vector kind", i);
      end
    end
    $display("Vectors run: %0d, errors: %0d", n_vec, errors);
    if ((errors == 0) && (n_vec > 0)) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog allows 8 cycles per vector plus reset
  initial begin
    wait (loaded);
    #((v_kind.size() * 8 + RST_CYCLES + 2) * CLK_PERIOD);
    $display("Watchdog expired before all vectors finished");
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/ex_stage_assert.sv */
////////////////////
// Execute stage checkers
// Handshake and reset properties, bound into the stage top
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ex_stage_assert (
  input logic clk,
  input logic rst_n,
  input logic mult_multicycle_i,
  input logic ex_ready_i,
  input logic branch_in_ex_i,
  input logic ex_valid_i,
  input logic wb_ready_i,
  input logic regfile_we_wb_i
);

  // High multiply in flight blocks the stage, a branch still resolves
  multicycle_blocks_ready: assert property (
    @(posedge clk) disable iff (!rst_n)
    mult_multicycle_i |-> (!ex_ready_i || branch_in_ex_i)
  ) else $error("ex_ready_o high while a high multiply is busy");

  // No instruction leaves EX without a WB slot
  valid_needs_wb: assert property (
    @(posedge clk) disable iff (!rst_n)
    ex_valid_i |-> wb_ready_i
  ) else $error("ex_valid_o high with wb_ready_i low");

  // EX/WB write enable starts cleared
  wb_we_clear_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |-> !regfile_we_wb_i
  ) else $error("regfile_we_wb_o set in the first cycle after reset");

endmodule

`default_nettype wire

/* verilog/ex_stage.sv */
////////////////////
// Execute stage top
// ALU, multiplier and control, branch result to fetch
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ex_stage import ex_op_pkg::*, ex_pipe_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  // ALU
  input  alu_op_e   alu_operator_i,
  input  logic      alu_en_i,
  input  word_t     alu_operand_a_i,
  input  word_t     alu_operand_b_i,
  input  word_t     alu_operand_c_i,   // Jump target
  // Multiplier
  input  mul_op_e   mult_operator_i,
  input  logic      mult_en_i,
  input  word_t     mult_operand_a_i,
  input  word_t     mult_operand_b_i,
  // CSR and LSU
  input  logic      csr_access_i,
  input  word_t     csr_rdata_i,
  input  logic      lsu_en_i,
  input  word_t     lsu_rdata_i,
  input  logic      lsu_ready_ex_i,
  input  logic      lsu_err_i,
  input  logic      branch_in_ex_i,
  // Register writes from decode
  input  logic      regfile_alu_we_i,
  input  reg_addr_t regfile_alu_waddr_i,
  input  logic      regfile_we_i,
  input  reg_addr_t regfile_waddr_i,
  input  logic      wb_ready_i,
  // To decode and fetch
  output logic      mult_multicycle_o,
  output logic      branch_decision_o,
  output word_t     jump_target_o,
  output logic      regfile_alu_we_fw_o,
  output reg_addr_t regfile_alu_waddr_fw_o,
  output word_t     regfile_alu_wdata_fw_o,
  output logic      regfile_we_wb_o,
  output reg_addr_t regfile_waddr_wb_o,
  output word_t     regfile_wdata_wb_o,
  output logic      ex_ready_o,
  output logic      ex_valid_o
);

  word_t alu_result;
  word_t mult_result;
  logic  mult_ready;

  assign jump_target_o = alu_operand_c_i;  // Computed in decode

  ////////////////////
  // ALU
  ////////////////////
  ex_alu u_alu (
    .operator_i          (alu_operator_i),
    .operand_a_i         (alu_operand_a_i),
    .operand_b_i         (alu_operand_b_i),
    .result_o            (alu_result),
    .comparison_result_o (branch_decision_o)
  );

  ////////////////////
  // Multiplier
  ////////////////////
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .operand_a_i  (mult_operand_a_i),
    .operand_b_i  (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  // Control and write ports
  ex_ctrl u_ctrl (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .mult_ready_i           (mult_ready),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .wb_ready_i             (wb_ready_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

`default_nettype wire

/* verilog/ex_ctrl.sv */
////////////////////
// Execute stage control
// Forwarding port mux, EX/WB register for the LSU port
// and the stage valid/ready handshake
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ex_ctrl import ex_pipe_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  // Unit enables from decode
  input  logic      alu_en_i,
  input  logic      mult_en_i,
  input  logic      csr_access_i,
  input  logic      lsu_en_i,
  input  logic      branch_in_ex_i,
  // Unit results
  input  word_t     alu_result_i,
  input  word_t     mult_result_i,
  input  word_t     csr_rdata_i,
  input  logic      mult_ready_i,
  input  logic      lsu_ready_ex_i,   // EX part of LSU done
  input  logic      lsu_err_i,
  input  word_t     lsu_rdata_i,
  input  logic      wb_ready_i,
  // Register write requests
  input  logic      regfile_alu_we_i,
  input  reg_addr_t regfile_alu_waddr_i,
  input  logic      regfile_we_i,
  input  reg_addr_t regfile_waddr_i,
  // Forwarding port
  output logic      regfile_alu_we_fw_o,
  output reg_addr_t regfile_alu_waddr_fw_o,
  output word_t     regfile_alu_wdata_fw_o,
  // Load/store port
  output logic      regfile_we_wb_o,
  output reg_addr_t regfile_waddr_wb_o,
  output word_t     regfile_wdata_wb_o,
  // Handshake
  output logic      ex_ready_o,
  output logic      ex_valid_o
);

  logic      units_ready;   // All units and WB can take a result
  logic      any_en;        // Real instruction present
  logic      lsu_we;
  logic      lsu_we_q;
  reg_addr_t lsu_waddr_q;

  ////////////////////
  // Forwarding port
  ////////////////////
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // CSR over multiplier over ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end
  end

  ////////////////////
  // EX/WB register
  ////////////////////
  assign lsu_we = regfile_we_i & ~lsu_err_i;  // Faulting access never writes

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q    <= 1'b0;
      lsu_waddr_q <= '0;
    end else if (ex_valid_o) begin      // wb_ready_i implied
      lsu_we_q <= lsu_we;
      if (lsu_we) lsu_waddr_q <= regfile_waddr_i;
    end else if (wb_ready_i) begin
      lsu_we_q <= 1'b0;                 // Bubble, flush the write
    end
  end

  assign regfile_we_wb_o    = lsu_we_q;
  assign regfile_waddr_wb_o = lsu_waddr_q;
  assign regfile_wdata_wb_o = lsu_rdata_i;  // Load data arrives in WB

  ////////////////////
  // Handshake
  ////////////////////
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign any_en      = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;

  // Branches resolve in EX, no WB slot needed
  assign ex_ready_o = units_ready | branch_in_ex_i;
  assign ex_valid_o = any_en & units_ready;  // Independent of ex_ready_o

endmodule

`default_nettype wire

/* verilog/ex_mult.sv */
////////////////////
// Integer multiplier
// MUL low word in one cycle, MULH/MULHSU/MULHU high word
// after EX_MULH_CYCLES cycles
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_mult import ex_op_pkg::*, ex_pipe_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    enable_i,
  input  mul_op_e operator_i,
  input  word_t   operand_a_i,
  input  word_t   operand_b_i,
  input  logic    ex_ready_i,    // Stage moves on this cycle
  output word_t   result_o,
  output logic    multicycle_o,  // High multiply still busy
  output logic    ready_o
);

  localparam int unsigned CNT_W = $clog2(`EX_MULH_CYCLES);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`EX_MULH_CYCLES - 1);

  logic                       sign_a;
  logic                       sign_b;
  logic signed [`EX_XLEN:0]   op_a_ext;   // 33 bit, covers both signednesses
  logic signed [`EX_XLEN:0]   op_b_ext;
  logic signed [2*`EX_XLEN+1:0] product;
  logic                       mulh;       // High multiply in EX
  logic [CNT_W-1:0]           cnt_q;      // Zero is idle
  word_t                      high_q;     // Registered high word

  ////////////////////
  // Shared multiplier array
  ////////////////////
  assign sign_a = (operator_i == MUL_MULH) || (operator_i == MUL_MULHSU);
  assign sign_b = (operator_i == MUL_MULH);

  assign op_a_ext = {sign_a & operand_a_i[`EX_XLEN-1], operand_a_i};
  assign op_b_ext = {sign_b & operand_b_i[`EX_XLEN-1], operand_b_i};
  assign product  = op_a_ext * op_b_ext;  // Low word is the same for any extension

  assign mulh = enable_i && (operator_i != MUL_MUL);

  ////////////////////
  // High multiply sequencing
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (mulh) begin
      if (cnt_q == CNT_LAST) begin
        if (ex_ready_i) cnt_q <= '0;  // Result taken, back to idle
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end else begin
      cnt_q <= '0;
    end
  end

  // Capture high word in the first cycle, decode holds operands meanwhile
  always_ff @(posedge clk) begin
    if (mulh && (cnt_q == '0)) begin
      high_q <= product[2*`EX_XLEN-1:`EX_XLEN];
    end
  end

  assign multicycle_o = mulh && (cnt_q != CNT_LAST);
  assign ready_o      = ~multicycle_o;   // Rises with the high word

  // MUL straight from the array, high variants from the register
  assign result_o = (operator_i == MUL_MUL) ? product[`EX_XLEN-1:0] : high_q;

endmodule

`default_nettype wire

/* verilog/ex_alu.sv */
////////////////////
// Integer ALU
// Add/sub, logic, shifts, set-less-than and branch compares
// Purely combinational
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_alu import ex_op_pkg::*, ex_pipe_pkg::*; (
  input  alu_op_e operator_i,
  input  word_t   operand_a_i,
  input  word_t   operand_b_i,
  output word_t   result_o,
  output logic    comparison_result_o
);

  localparam int unsigned SHAMT_W = $clog2(`EX_XLEN);

  // Bit reversal, lets the right shifter serve left shifts too
  function automatic word_t bit_rev(input word_t v);
    word_t r;
    for (int i = 0; i < `EX_XLEN; i++) begin
      r[i] = v[`EX_XLEN-1-i];
    end
    return r;
  endfunction

  logic               is_sub;    // Adder subtracts
  logic               is_signed; // Compare as signed
  logic [`EX_XLEN:0]  op_a_ext;  // One guard bit above the word
  logic [`EX_XLEN:0]  op_b_ext;
  logic [`EX_XLEN:0]  adder_res;
  logic               is_eq;
  logic               is_lt;

  logic                       shift_left;
  logic                       shift_arith;
  logic [SHAMT_W-1:0]         shamt;
  word_t                      shift_in;
  logic signed [`EX_XLEN:0]   shift_ext;
  logic [`EX_XLEN:0]          shift_res;
  word_t                      shift_right;

  ////////////////////
  // Shared adder
  ////////////////////
  assign is_sub = (operator_i == ALU_SUB) || (operator_i == ALU_SLT) ||
                  (operator_i == ALU_SLTU) || (operator_i == ALU_LT) ||
                  (operator_i == ALU_GE) || (operator_i == ALU_LTU) ||
                  (operator_i == ALU_GEU);
  assign is_signed = (operator_i == ALU_SLT) || (operator_i == ALU_LT) ||
                     (operator_i == ALU_GE);

  // Sign or zero guard bit, so bit XLEN of a difference is the less-than flag
  assign op_a_ext  = {is_signed & operand_a_i[`EX_XLEN-1], operand_a_i};
  assign op_b_ext  = {is_signed & operand_b_i[`EX_XLEN-1], operand_b_i};
  assign adder_res = op_a_ext + (op_b_ext ^ {(`EX_XLEN+1){is_sub}}) +
                     {{`EX_XLEN{1'b0}}, is_sub};  // Two's complement subtract

  ////////////////////
  // Comparator
  ////////////////////
  assign is_eq = (operand_a_i == operand_b_i);
  assign is_lt = adder_res[`EX_XLEN];

  always_comb begin
    case (operator_i)
      ALU_EQ:                                    comparison_result_o = is_eq;
      ALU_NE:                                    comparison_result_o = ~is_eq;
      ALU_SLT, ALU_SLTU, ALU_LT, ALU_LTU:        comparison_result_o = is_lt;
      ALU_GE, ALU_GEU:                           comparison_result_o = ~is_lt;
      default:                                   comparison_result_o = 1'b0;
    endcase
  end

  ////////////////////
  // Barrel shifter
  ////////////////////
  assign shift_left  = (operator_i == ALU_SLL);
  assign shift_arith = (operator_i == ALU_SRA);
  assign shamt       = operand_b_i[SHAMT_W-1:0];  // Only low bits count
  assign shift_in    = shift_left ? bit_rev(operand_a_i) : operand_a_i;
  assign shift_ext   = {shift_arith & operand_a_i[`EX_XLEN-1], shift_in};
  assign shift_res   = shift_ext >>> shamt;        // Fill bit from guard
  assign shift_right = shift_res[`EX_XLEN-1:0];

  // Result mux
  always_comb begin
    case (operator_i)
      ALU_ADD, ALU_SUB: result_o = adder_res[`EX_XLEN-1:0];
      ALU_XOR:          result_o = operand_a_i ^ operand_b_i;
      ALU_OR:           result_o = operand_a_i | operand_b_i;
      ALU_AND:          result_o = operand_a_i & operand_b_i;
      ALU_SLL:          result_o = bit_rev(shift_right);
      ALU_SRL, ALU_SRA: result_o = shift_right;
      default:          result_o = {{(`EX_XLEN-1){1'b0}}, comparison_result_o}; // SLT, branches
    endcase
  end

endmodule

`default_nettype wire

/* verilog/ex_pipe_pkg.sv */
////////////////////
// Execute stage data types
// Data word and register address shared by the pipeline blocks
////////////////////

`default_nettype none

`include "ex_macros.svh"

package ex_pipe_pkg;

  ////////////////////
  // Payload types
  ////////////////////

  // One integer data word
  typedef logic [`EX_XLEN-1:0] word_t;

  // One register file address
  typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

endpackage

`default_nettype wire

/* verilog/ex_op_pkg.sv */
////////////////////
// Execute stage operation codes
// ALU and multiplier operator encodings
////////////////////

`default_nettype none

package ex_op_pkg;

  ////////////////////
  // ALU operators
  ////////////////////
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_XOR  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_AND  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,  // Set less than, signed
    ALU_SLTU = 4'h9,  // Set less than, unsigned
    ALU_EQ   = 4'ha,  // Branch comparisons from here on
    ALU_NE   = 4'hb,
    ALU_LT   = 4'hc,
    ALU_GE   = 4'hd,
    ALU_LTU  = 4'he,
    ALU_GEU  = 4'hf
  } alu_op_e;

  ////////////////////
  // Multiplier operators
  ////////////////////
  typedef enum logic [1:0] {
    MUL_MUL    = 2'd0,  // Low word, single cycle
    MUL_MULH   = 2'd1,  // High word, signed x signed
    MUL_MULHSU = 2'd2,  // High word, signed x unsigned
    MUL_MULHU  = 2'd3   // High word, unsigned x unsigned
  } mul_op_e;

endpackage

`default_nettype wire

/* verilog/ex_macros.svh */
////////////////////
// Execute stage global sizes
// Data path width, register address width and high multiply latency
////////////////////

`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

////////////////////
// Data path
////////////////////

// Integer register width, RV32
`define EX_XLEN 32

// Register file address, one extra bit above the 32 GPRs
`define EX_REG_ADDR_W 6

////////////////////
// Multiplier latency
////////////////////

// Cycles MULH/MULHSU/MULHU occupy the stage, result in the last one
`define EX_MULH_CYCLES 3

`endif
